// File: design/wcache_pkg.sv
// Weight cache sizes, width typedefs, read record struct and session state enum
package wcache_pkg;

    // ============================================================
    // Sizes
    // ============================================================
    localparam int NUM_PORTS   = 4;     // PE-row request ports
    localparam int ADDR_W      = 13;    // WRAM word address
    localparam int DATA_W      = 8;     // Weight word
    localparam int QUEUE_DEPTH = 4;     // Reads in flight

    localparam int PORT_IDX_W  = $clog2(NUM_PORTS);
    localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
    localparam int QUEUE_CNT_W = $clog2(QUEUE_DEPTH + 1);   // Holds 0 to QUEUE_DEPTH

    // ============================================================
    // Width types
    // ============================================================
    typedef logic [NUM_PORTS-1:0]   port_mask_t;    // One bit per port
    typedef logic [ADDR_W-1:0]      wram_addr_t;
    typedef logic [DATA_W-1:0]      weight_t;
    typedef logic [PORT_IDX_W-1:0]  port_idx_t;
    typedef logic [QUEUE_PTR_W-1:0] queue_ptr_t;
    typedef logic [QUEUE_CNT_W-1:0] queue_cnt_t;

    // Per-port bundles, port 0 in the low slot
    typedef wram_addr_t [NUM_PORTS-1:0] port_addr_t;
    typedef weight_t    [NUM_PORTS-1:0] port_weight_t;

    // ============================================================
    // Issued read record
    // ============================================================
    // One record per WRAM read or per reuse hit, kept in issue order
    typedef struct packed {
        logic       reuse;  // Served from the last word, no WRAM data
        port_mask_t mask;   // Ports to answer
        port_mask_t lst;    // Last flags of those ports
        wram_addr_t addr;
    } read_rec_t;

    // Session control
    typedef enum logic [1:0] {
        IDLE = 2'b00,
        CFG  = 2'b01,
        WORK = 2'b10
    } session_state_t;

endpackage

// File: design/request_arbiter.sv
// Session FSM, fixed-priority port arbiter, same-address merge, reuse check and queue push
`timescale 1ns/1ps

module request_arbiter (
    input  logic                       clk,
    input  logic                       rst_n,
    // Configuration
    input  logic                       cfg_info_vld,
    input  logic                       cfg_wbuf_ena,
    output logic                       cfg_info_rdy,
    // PE-row request ports
    input  wcache_pkg::port_mask_t     req_vld,
    input  wcache_pkg::port_mask_t     req_lst,
    input  wcache_pkg::port_addr_t     req_addr,
    output wcache_pkg::port_mask_t     req_rdy,
    // WRAM read address
    output logic                       wram_add_vld,
    output logic                       wram_add_lst,
    output wcache_pkg::wram_addr_t     wram_add_addr,
    input  logic                       wram_add_rdy,
    // Pending queue
    output logic                       push,
    output wcache_pkg::read_rec_t      push_rec,
    input  logic                       full
);

    wcache_pkg::session_state_t state;
    wcache_pkg::session_state_t state_nxt;

    logic                       reuse_en;
    wcache_pkg::wram_addr_t     last_addr;     // Address of the most recent WRAM read
    logic                       last_vld;

    wcache_pkg::port_idx_t      win_idx;
    logic                       any_vld;
    wcache_pkg::wram_addr_t     win_addr;
    wcache_pkg::port_mask_t     merge_mask;
    logic                       can_issue;
    logic                       reuse_hit;

    // ============================================================
    // Session FSM
    // ============================================================
    always_comb begin
        state_nxt = state;
        case (state)
            wcache_pkg::IDLE: if (cfg_info_vld) state_nxt = wcache_pkg::CFG;
            wcache_pkg::CFG:  state_nxt = wcache_pkg::WORK;
            wcache_pkg::WORK: if (cfg_info_vld) state_nxt = wcache_pkg::IDLE;   // End of session
            default:          state_nxt = wcache_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= wcache_pkg::IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    assign cfg_info_rdy = (state == wcache_pkg::IDLE);

    // Reuse mode is latched once per session
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            reuse_en <= 1'b0;
        end else if (state == wcache_pkg::IDLE) begin
            reuse_en <= 1'b0;
        end else if (state == wcache_pkg::CFG) begin
            reuse_en <= cfg_wbuf_ena;
        end
    end

    // Reads return in order, so the last issued address names the next last word
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_addr <= '0;
            last_vld  <= 1'b0;
        end else if (state == wcache_pkg::IDLE) begin
            last_addr <= '0;
            last_vld  <= 1'b0;
        end else if (wram_add_vld && wram_add_rdy) begin
            last_addr <= win_addr;
            last_vld  <= 1'b1;
        end
    end

    // ============================================================
    // Arbitration and merge
    // ============================================================
    // Lowest valid index wins
    always_comb begin
        win_idx = '0;
        any_vld = 1'b0;
        for (int i = wcache_pkg::NUM_PORTS - 1; i >= 0; i--) begin
            if (req_vld[i]) begin
                win_idx = wcache_pkg::port_idx_t'(i);
                any_vld = 1'b1;
            end
        end
    end

    assign win_addr = req_addr[win_idx];

    // Every port asking for the winner's word rides on the same read
    always_comb begin
        merge_mask = '0;
        for (int i = 0; i < wcache_pkg::NUM_PORTS; i++) begin
            merge_mask[i] = req_vld[i] && (req_addr[i] == win_addr);
        end
    end

    assign can_issue = (state == wcache_pkg::WORK) && !full && any_vld;
    assign reuse_hit = reuse_en && last_vld && (win_addr == last_addr);

    // ============================================================
    // WRAM read and queue push
    // ============================================================
    assign wram_add_vld  = can_issue && !reuse_hit;
    assign wram_add_lst  = req_lst[win_idx];   // Winner's flag only
    assign wram_add_addr = win_addr;

    assign push    = can_issue && (reuse_hit || wram_add_rdy);
    assign req_rdy = {wcache_pkg::NUM_PORTS{push}} & merge_mask;

    always_comb begin
        push_rec.reuse = reuse_hit;
        push_rec.mask  = merge_mask;
        push_rec.lst   = req_lst & merge_mask;
        push_rec.addr  = win_addr;
    end

endmodule

// File: design/pending_queue.sv
// In-order FIFO of issued read records with full flag and head output
`timescale 1ns/1ps

module pending_queue (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    push,
    input  wcache_pkg::read_rec_t   push_rec,
    output logic                    full,
    input  logic                    pop,
    output logic                    head_vld,
    output wcache_pkg::read_rec_t   head
);

    wcache_pkg::read_rec_t  mem [wcache_pkg::QUEUE_DEPTH];
    wcache_pkg::queue_ptr_t wr_ptr;
    wcache_pkg::queue_ptr_t rd_ptr;
    wcache_pkg::queue_cnt_t count;
    logic                   do_push;
    logic                   do_pop;

    // Wrap at QUEUE_DEPTH, depth need not be a power of two
    function automatic wcache_pkg::queue_ptr_t next_ptr(input wcache_pkg::queue_ptr_t ptr);
        wcache_pkg::queue_ptr_t last;
        last = wcache_pkg::queue_ptr_t'(wcache_pkg::QUEUE_DEPTH - 1);
        if (ptr == last) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign do_push = push && !full;
    assign do_pop  = pop && head_vld;

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_rec;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= next_ptr(wr_ptr);
            if (do_pop)  rd_ptr <= next_ptr(rd_ptr);
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // Both or neither
            endcase
        end
    end

    // ============================================================
    // Status and head
    // ============================================================
    assign full     = (count == wcache_pkg::queue_cnt_t'(wcache_pkg::QUEUE_DEPTH));
    assign head_vld = (count != '0);
    assign head     = mem[rd_ptr];

endmodule

// File: design/response_router.sv
// Last-word register and fan-out of WRAM or reused data to the response ports
`timescale 1ns/1ps

module response_router (
    input  logic                       clk,
    input  logic                       rst_n,
    // Queue head
    input  logic                       head_vld,
    input  wcache_pkg::read_rec_t      head,
    output logic                       pop,
    // WRAM read data
    input  logic                       wram_dat_vld,
    input  wcache_pkg::weight_t        wram_dat_dat,
    output logic                       wram_dat_rdy,
    // PE-row response ports
    output wcache_pkg::port_mask_t     rsp_vld,
    output wcache_pkg::port_mask_t     rsp_lst,
    output wcache_pkg::port_weight_t   rsp_dat,
    input  wcache_pkg::port_mask_t     rsp_rdy
);

    wcache_pkg::weight_t    last_word;     // Word of the last completed record
    wcache_pkg::weight_t    sel_word;
    logic                   data_avail;
    logic                   all_rdy;
    logic                   done;

    // ============================================================
    // Data select
    // ============================================================
    // Reuse records need no WRAM beat
    assign data_avail = head_vld && (head.reuse || wram_dat_vld);
    assign sel_word   = head.reuse ? last_word : wram_dat_dat;

    // Ports outside the mask never hold a record back
    assign all_rdy = &(rsp_rdy | ~head.mask);
    assign done    = data_avail && all_rdy;

    assign pop          = done;
    assign wram_dat_rdy = head_vld && !head.reuse && all_rdy;

    // ============================================================
    // Fan-out
    // ============================================================
    always_comb begin
        for (int p = 0; p < wcache_pkg::NUM_PORTS; p++) begin
            rsp_vld[p] = data_avail && head.mask[p];
            rsp_lst[p] = data_avail && head.lst[p];
            rsp_dat[p] = sel_word;   // Same word on every port
        end
    end

    // Loaded on every completion, reuse records just reload the same word
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_word <= '0;
        end else if (done) begin
            last_word <= sel_word;
        end
    end

endmodule

// File: design/weight_cache_top.sv
// Weight cache top level with arbiter, pending queue and response router
`timescale 1ns/1ps

module weight_cache_top (
    input  logic                       clk,
    input  logic                       rst_n,
    // Configuration
    input  logic                       cfg_info_vld,
    input  logic                       cfg_wbuf_ena,
    output logic                       cfg_info_rdy,
    // PE-row requests
    input  wcache_pkg::port_mask_t     req_vld,
    input  wcache_pkg::port_mask_t     req_lst,
    input  wcache_pkg::port_addr_t     req_addr,
    output wcache_pkg::port_mask_t     req_rdy,
    // PE-row responses
    output wcache_pkg::port_mask_t     rsp_vld,
    output wcache_pkg::port_mask_t     rsp_lst,
    output wcache_pkg::port_weight_t   rsp_dat,
    input  wcache_pkg::port_mask_t     rsp_rdy,
    // WRAM address side
    output logic                       wram_add_vld,
    output logic                       wram_add_lst,
    output wcache_pkg::wram_addr_t     wram_add_addr,
    input  logic                       wram_add_rdy,
    // WRAM data side
    input  logic                       wram_dat_vld,
    input  wcache_pkg::weight_t        wram_dat_dat,
    output logic                       wram_dat_rdy
);

    logic                   push;
    wcache_pkg::read_rec_t  push_rec;
    logic                   full;
    logic                   pop;
    logic                   head_vld;
    wcache_pkg::read_rec_t  head;

    request_arbiter arb_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .cfg_info_vld  (cfg_info_vld),
        .cfg_wbuf_ena  (cfg_wbuf_ena),
        .cfg_info_rdy  (cfg_info_rdy),
        .req_vld       (req_vld),
        .req_lst       (req_lst),
        .req_addr      (req_addr),
        .req_rdy       (req_rdy),
        .wram_add_vld  (wram_add_vld),
        .wram_add_lst  (wram_add_lst),
        .wram_add_addr (wram_add_addr),
        .wram_add_rdy  (wram_add_rdy),
        .push          (push),
        .push_rec      (push_rec),
        .full          (full)
    );

    // Issue-order records, at most QUEUE_DEPTH reads in flight
    pending_queue queue_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .push     (push),
        .push_rec (push_rec),
        .full     (full),
        .pop      (pop),
        .head_vld (head_vld),
        .head     (head)
    );

    response_router router_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .head_vld     (head_vld),
        .head         (head),
        .pop          (pop),
        .wram_dat_vld (wram_dat_vld),
        .wram_dat_dat (wram_dat_dat),
        .wram_dat_rdy (wram_dat_rdy),
        .rsp_vld      (rsp_vld),
        .rsp_lst      (rsp_lst),
        .rsp_dat      (rsp_dat),
        .rsp_rdy      (rsp_rdy)
    );

endmodule

// File: verif/tb_clock_gen.sv
// Testbench clock and active-low reset generator
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    localparam int RESET_CYCLES = 5;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;   // 10 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end

endmodule

// File: verif/weight_cache_props.sv
// Bound assertions on pending queue push, pop and occupancy rules
`timescale 1ns/1ps

module weight_cache_props (
    input logic clk,
    input logic rst_n,
    input logic push,
    input logic pop,
    input logic full,
    input logic head_vld
);

    int unsigned fail_cnt = 0;   // Failed assertions so far

    // No record may enter a full queue
    push_not_full: assert property (@(posedge clk) disable iff (!rst_n) push |-> !full)
        else begin
            fail_cnt++;
            $error("Record pushed while the pending queue is full");
        end

    // Router only completes records that exist
    pop_not_empty: assert property (@(posedge clk) disable iff (!rst_n) pop |-> head_vld)
        else begin
            fail_cnt++;
            $error("Record popped while the pending queue is empty");
        end

    // A pushed record is visible at the head on the next cycle
    push_then_head: assert property (@(posedge clk) disable iff (!rst_n) push |=> head_vld)
        else begin
            fail_cnt++;
            $error("Pending queue empty right after a push");
        end

endmodule

bind pending_queue weight_cache_props props_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .push     (push),
    .pop      (pop),
    .full     (full),
    .head_vld (head_vld)
);

// File: verif/weight_cache_tb.sv
// Weight cache testbench with stimulus table, WRAM model, LFSR stalls, checks and timeout
`timescale 1ns/1ps

module weight_cache_tb;

    localparam int NP          = wcache_pkg::NUM_PORTS;
    localparam int NUM_STIM    = 22;
    localparam int NUM_SESS    = 4;
    localparam int CYCLE_LIMIT = 40 * NUM_STIM;
    localparam int HOLD_CYCLES = 6;      // rsp_rdy held low at session start

    typedef struct packed {
        wcache_pkg::port_idx_t  port;
        wcache_pkg::wram_addr_t addr;
        logic                   lst;
        logic                   mode;    // Reuse enable of the session
    } stim_t;

    // A new session starts wherever mode changes
    stim_t stim [NUM_STIM] = '{
        '{2'd0, 13'h0010, 1'b0, 1'b0}, '{2'd0, 13'h0011, 1'b0, 1'b0},   // Port 0 only
        '{2'd0, 13'h0010, 1'b0, 1'b0}, '{2'd0, 13'h01ff, 1'b0, 1'b0},
        '{2'd0, 13'h10a5, 1'b1, 1'b0},
        '{2'd2, 13'h0123, 1'b0, 1'b1}, '{2'd2, 13'h0123, 1'b0, 1'b1},   // One address repeated
        '{2'd2, 13'h0123, 1'b0, 1'b1}, '{2'd2, 13'h0123, 1'b0, 1'b1},
        '{2'd2, 13'h0123, 1'b1, 1'b1},
        '{2'd0, 13'h0777, 1'b1, 1'b0}, '{2'd1, 13'h0777, 1'b1, 1'b0},   // Four-way merge
        '{2'd2, 13'h0777, 1'b1, 1'b0}, '{2'd3, 13'h0777, 1'b1, 1'b0},
        '{2'd0, 13'h0040, 1'b0, 1'b1}, '{2'd0, 13'h0041, 1'b1, 1'b1},   // Mixed traffic
        '{2'd1, 13'h0040, 1'b0, 1'b1}, '{2'd1, 13'h0100, 1'b1, 1'b1},
        '{2'd2, 13'h1abc, 1'b0, 1'b1}, '{2'd2, 13'h0041, 1'b1, 1'b1},
        '{2'd3, 13'h00fe, 1'b0, 1'b1}, '{2'd3, 13'h00fe, 1'b1, 1'b1}
    };
    // Mixed session: 0x40 merged, second 0xfe reused, the rest read
    int exp_reads [NUM_SESS] = '{5, 1, 1, 6};

    logic clk, rst_n;
    logic cfg_info_vld, cfg_wbuf_ena, cfg_info_rdy;
    wcache_pkg::port_mask_t   req_vld, req_lst, req_rdy;
    wcache_pkg::port_addr_t   req_addr;
    wcache_pkg::port_mask_t   rsp_vld, rsp_lst, rsp_rdy;
    wcache_pkg::port_weight_t rsp_dat;
    logic wram_add_vld, wram_add_lst, wram_add_rdy;
    wcache_pkg::wram_addr_t   wram_add_addr;
    logic wram_dat_vld, wram_dat_rdy;
    wcache_pkg::weight_t      wram_dat_dat;

    int req_q [NP][$];                       // Stim indices not yet accepted
    int exp_q [NP][$];                       // Stim indices not yet answered
    wcache_pkg::wram_addr_t   wram_q [$];    // Reads accepted by the WRAM model
    int dat_delay;
    int n_reads;
    int hold_left;
    int errors;
    int cycle_cnt = 0;
    logic [31:0] lfsr_state;
    wcache_pkg::port_mask_t   stall_prev;
    wcache_pkg::port_weight_t stall_dat;

    tb_clock_gen clk_gen_i (.clk(clk), .rst_n(rst_n));

    weight_cache_top dut_i (.*);

    // ============================================================
    // Helpers
    // ============================================================
    function automatic wcache_pkg::weight_t weight_of(input wcache_pkg::wram_addr_t addr);
        return addr[7:0] ^ 8'h5a;
    endfunction

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // Taps 32 22 2 1
    endfunction

    task automatic draw_bits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            val = {val[30:0], lfsr_state[0]};
        end
    endtask

    task automatic fail_run();
        $display("sim failed");
        $fatal(1, "Run stopped at the first failure");
    endtask

    task automatic check_weight(input string what, input wcache_pkg::weight_t got,
                                input wcache_pkg::weight_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t: %s is 8'h%02h, expected 8'h%02h", $time, what, got, exp);
            errors++;
            fail_run();
        end
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        if (got != exp) begin
            $display("[ERROR] %0t: %s is %0d, expected %0d", $time, what, got, exp);
            errors++;
            fail_run();
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp);
            errors++;
            fail_run();
        end
    endtask

    function automatic logic drained();
        for (int p = 0; p < NP; p++) begin
            if (req_q[p].size() != 0 || exp_q[p].size() != 0) return 1'b0;
        end
        return wram_q.size() == 0;
    endfunction

    // ============================================================
    // Per-cycle sampling and driving
    // ============================================================
    // A WRAM read carries the last flag of the lowest-index requesting port
    task automatic check_issue();
        int win;
        win = -1;
        for (int p = NP - 1; p >= 0; p--) begin
            if (req_q[p].size() != 0) win = p;
        end
        if (win < 0) begin
            $display("[ERROR] %0t: WRAM read issued with no request pending", $time);
            errors++;
            fail_run();
        end else begin
            check_flag("wram_add_lst", wram_add_lst, stim[req_q[win][0]].lst);
        end
    endtask

    task automatic check_responses();
        int   idx;
        logic rec_done;
        rec_done = &(rsp_rdy | ~rsp_vld);   // Record completes with all its ports ready
        for (int p = 0; p < NP; p++) begin
            if (stall_prev[p]) begin   // Held response must not move
                check_flag($sformatf("rsp_vld[%0d] under stall", p), rsp_vld[p], 1'b1);
                check_weight($sformatf("rsp_dat[%0d] under stall", p), rsp_dat[p], stall_dat[p]);
            end
            if (rsp_vld[p] && rec_done) begin
                if (exp_q[p].size() == 0) begin
                    $display("[ERROR] %0t: response on port %0d with no request open", $time, p);
                    errors++;
                    fail_run();
                end else begin
                    idx = exp_q[p].pop_front();
                    check_weight($sformatf("rsp_dat[%0d]", p), rsp_dat[p],
                                 weight_of(stim[idx].addr));
                    check_flag($sformatf("rsp_lst[%0d]", p), rsp_lst[p], stim[idx].lst);
                end
            end
        end
        stall_prev = rec_done ? '0 : rsp_vld;
        stall_dat  = rsp_dat;
    endtask

    task automatic drive_inputs();
        int v;
        for (int p = 0; p < NP; p++) begin
            if (req_q[p].size() != 0) begin
                req_vld[p]  = 1'b1;
                req_addr[p] = stim[req_q[p][0]].addr;
                req_lst[p]  = stim[req_q[p][0]].lst;
            end else begin
                req_vld[p] = 1'b0;
            end
            if (hold_left > 0) begin
                rsp_rdy[p] = 1'b0;
            end else begin
                draw_bits(2, v);
                rsp_rdy[p] = (v != 0);   // Stall one cycle in four
            end
        end
        if (hold_left > 0) hold_left--;
    endtask

    // WRAM answers in order after 1 to 4 cycles
    task automatic step_wram(input logic add_hs, input logic dat_hs,
                             input wcache_pkg::wram_addr_t add_addr);
        int v;
        if (dat_hs) begin
            void'(wram_q.pop_front());
            wram_dat_vld = 1'b0;
            draw_bits(2, v);
            dat_delay = v + 1;
        end
        if (add_hs) begin
            wram_q.push_back(add_addr);
            n_reads++;
        end
        if (wram_q.size() != 0 && !wram_dat_vld) begin
            if (dat_delay > 1) begin
                dat_delay--;
            end else begin
                wram_dat_vld = 1'b1;
                wram_dat_dat = weight_of(wram_q[0]);
            end
        end
    endtask

    // Samples at the falling edge, drives 1 ns after the rising edge
    task automatic run_cycle();
        wcache_pkg::port_mask_t req_hs;
        logic                   add_hs;
        logic                   dat_hs;
        wcache_pkg::wram_addr_t add_addr;
        @(negedge clk);
        req_hs   = req_vld & req_rdy;
        add_hs   = wram_add_vld && wram_add_rdy;
        dat_hs   = wram_dat_vld && wram_dat_rdy;
        add_addr = wram_add_addr;
        if (add_hs) check_issue();
        check_responses();
        @(posedge clk);
        #1;
        for (int p = 0; p < NP; p++) begin
            if (req_hs[p]) void'(req_q[p].pop_front());
        end
        step_wram(add_hs, dat_hs, add_addr);
        drive_inputs();
    endtask

    // ============================================================
    // Sessions
    // ============================================================
    task automatic run_session(input int first, input int last, input int sess);
        for (int i = first; i <= last; i++) begin
            req_q[stim[i].port].push_back(i);
            exp_q[stim[i].port].push_back(i);
        end
        n_reads    = 0;
        hold_left  = HOLD_CYCLES;
        stall_prev = '0;
        check_flag("cfg_info_rdy in IDLE", cfg_info_rdy, 1'b1);
        cfg_info_vld = 1'b1;
        cfg_wbuf_ena = stim[first].mode;
        @(posedge clk);
        #1;
        cfg_info_vld = 1'b0;
        check_flag("cfg_info_rdy after start pulse", cfg_info_rdy, 1'b0);
        @(posedge clk);   // CFG samples cfg_wbuf_ena here
        #1;
        drive_inputs();
        while (!drained()) begin
            run_cycle();
        end
        check_count($sformatf("WRAM reads in session %0d", sess), n_reads, exp_reads[sess]);
        check_flag("cfg_info_rdy in WORK", cfg_info_rdy, 1'b0);
        cfg_info_vld = 1'b1;
        @(posedge clk);
        #1;
        cfg_info_vld = 1'b0;
        check_flag("cfg_info_rdy after end pulse", cfg_info_rdy, 1'b1);
    endtask

    always @(posedge clk) begin
        cycle_cnt++;
        if (dut_i.queue_i.props_i.fail_cnt != 0) begin
            $display("A bound assertion on the pending queue failed");
            fail_run();
        end else if (cycle_cnt > CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, the cache stopped making progress", cycle_cnt);
            fail_run();
        end
    end

    initial begin
        int first;
        int sess;
        int v;
        lfsr_state   = 32'h2ef3b094;
        cfg_info_vld = 1'b0;
        cfg_wbuf_ena = 1'b0;
        req_vld      = '0;
        req_lst      = '0;
        req_addr     = '0;
        rsp_rdy      = '0;
        wram_add_rdy = 1'b1;   // Address side never stalls
        wram_dat_vld = 1'b0;
        wram_dat_dat = '0;
        errors       = 0;
        n_reads      = 0;
        hold_left    = 0;
        stall_prev   = '0;
        stall_dat    = '0;
        draw_bits(2, v);
        dat_delay = v + 1;
        wait (rst_n === 1'b1);
        @(posedge clk);
        #1;
        check_flag("cfg_info_rdy after reset", cfg_info_rdy, 1'b1);
        check_flag("rsp_vld after reset", |rsp_vld, 1'b0);
        check_flag("req_rdy after reset", |req_rdy, 1'b0);
        check_flag("wram_add_vld after reset", wram_add_vld, 1'b0);
        check_flag("wram_dat_rdy after reset", wram_dat_rdy, 1'b0);
        first = 0;
        sess  = 0;
        for (int i = 0; i < NUM_STIM; i++) begin
            if (i == NUM_STIM - 1 || stim[i + 1].mode != stim[i].mode) begin
                run_session(first, i, sess);
                first = i + 1;
                sess++;
            end
        end
        if (errors == 0 && dut_i.queue_i.props_i.fail_cnt == 0) begin
            $display("sim passed");
            $finish;
        end else begin
            fail_run();
        end
    end

endmodule

// File: weight_cache.f
design/wcache_pkg.sv
design/request_arbiter.sv
design/pending_queue.sv
design/response_router.sv
design/weight_cache_top.sv
verif/tb_clock_gen.sv
verif/weight_cache_props.sv
verif/weight_cache_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the weight cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module weight_cache_tb -f weight_cache.f -o weight_cache_sim

./obj_dir/weight_cache_sim | tee sim.log

if grep -qx "sim passed" sim.log; then
    echo "PASS: weight cache simulation"
else
    echo "FAIL: weight cache simulation, see sim.log"
    exit 1
fi
